// File: xfer_pkg.sv
// Shared types and widths for the host-interface transmit queues and the transfer issuer
package xfer_pkg;

  // Width of one software register write
  parameter int unsigned CsrDataWidth = 32;

  // Threshold fields as seen by software
  parameter int unsigned ThldWidth = 3;

  // Queue fill level, wide enough for depths up to 64
  parameter int unsigned QDepthWidth = 7;

  // Transfer opcodes, only writes carry payload words
  typedef enum logic [1:0] {
    OP_WRITE = 2'd0,
    OP_READ  = 2'd1,
    OP_NOP   = 2'd2
  } xfer_op_e;

  typedef enum logic [1:0] {
    ISS_IDLE  = 2'd0,
    ISS_FETCH = 2'd1,
    ISS_BEAT  = 2'd2
  } issuer_state_e;

  // Command descriptor, low dword is written first
  typedef struct packed {
    logic [31:0] tag;
    logic [14:0] rsvd;
    logic [7:0]  len;
    logic [6:0]  addr;
    xfer_op_e    op;
  } cmd_desc_t;

  // One outgoing transfer beat
  typedef struct packed {
    xfer_op_e    op;
    logic [6:0]  addr;
    logic [31:0] tag;
    logic [31:0] data;
    logic        last;
  } xfer_beat_t;

  typedef struct packed {
    logic [QDepthWidth-1:0] depth;
    logic                   full;
    logic                   empty;
    logic                   start_trig;
    logic                   ready_trig;
  } queue_status_t;

  typedef struct packed {
    logic [ThldWidth-1:0] start_thld;
    logic [ThldWidth-1:0] ready_thld;
  } thld_cfg_t;

endpackage

// File: queue_fifo.sv
// Synchronous circular-buffer FIFO with valid/ready on both sides, used inside each write queue
`timescale 1ns/1ps

module queue_fifo #(
  parameter int unsigned Width = 32,
  parameter int unsigned Depth = 16
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                clr_i,
  input  logic                                wvalid_i,
  output logic                                wready_o,
  input  logic [Width-1:0]                    wdata_i,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output logic [Width-1:0]                    rdata_o,
  output logic [xfer_pkg::QDepthWidth-1:0]    depth_o,
  output logic                                full_o
);
  import xfer_pkg::*;

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;

  logic [Width-1:0]       mem_q [Depth];
  logic [PtrWidth-1:0]    wr_ptr_q;
  logic [PtrWidth-1:0]    rd_ptr_q;
  logic [QDepthWidth-1:0] count_q;
  logic                   push;
  logic                   pop;

  assign full_o   = (count_q == QDepthWidth'(Depth));
  assign wready_o = ~full_o;
  assign rvalid_o = (count_q != '0);
  assign rdata_o  = mem_q[rd_ptr_q];
  assign depth_o  = count_q;

  // A clear wins over any transfer in the same cycle
  assign push = wvalid_i & wready_o & ~clr_i;
  assign pop  = rvalid_o & rready_i & ~clr_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clr_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  a_count_in_range: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= QDepthWidth'(Depth))
    else $error("FIFO count above depth");

  // The consumer must only ask for a word that is there
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rready_i |-> rvalid_o)
    else $error("FIFO read requested while empty");

endmodule

// File: write_queue.sv
// Software write queue that packs register writes into FIFO entries and reports fill triggers
`timescale 1ns/1ps

module write_queue #(
  parameter int unsigned Depth          = 16,
  parameter int unsigned DataWidth      = 32,
  parameter bit          ThldIsPow      = 1'b0,
  parameter bit          LimitReadyThld = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                req_i,
  input  logic [xfer_pkg::CsrDataWidth-1:0]   data_i,
  output logic                                ack_o,
  input  xfer_pkg::thld_cfg_t                 thld_i,
  output xfer_pkg::queue_status_t             status_o,
  output logic                                rvalid_o,
  input  logic                                rready_i,
  output logic [DataWidth-1:0]                rdata_o,
  input  logic                                reg_rst_i,
  output logic                                reg_rst_we_o
);
  import xfer_pkg::*;

  logic                   fifo_wvalid_q;
  logic                   fifo_wready;
  logic [DataWidth-1:0]   fifo_wdata_q;
  logic [QDepthWidth-1:0] fifo_depth;
  logic [QDepthWidth-1:0] free_entries;
  logic                   fifo_full;
  logic                   fifo_empty;
  logic [ThldWidth-1:0]   ready_thld_d;
  logic [ThldWidth-1:0]   ready_thld_q;

  // Threshold code to entry count, power mode reads n as 2^(n+1)
  function automatic int unsigned thld_level(logic [ThldWidth-1:0] thld);
    int unsigned lvl;
    lvl = ThldIsPow ? (32'd1 << (32'(thld) + 32'd1)) : 32'(thld);
    return lvl;
  endfunction

  assign fifo_empty   = ~|fifo_depth;
  assign free_entries = QDepthWidth'(Depth) - fifo_depth;

  always_comb begin
    status_o.depth      = fifo_depth;
    status_o.full       = fifo_full;
    status_o.empty      = fifo_empty;
    status_o.start_trig = |thld_i.start_thld &&
                          (32'(fifo_depth) >= thld_level(thld_i.start_thld));
    status_o.ready_trig = |ready_thld_q &&
                          (32'(free_entries) >= thld_level(ready_thld_q));
  end

  // Optional clamp so the ready level stays reachable
  always_comb begin
    ready_thld_d = thld_i.ready_thld;
    if (LimitReadyThld) begin
      if (ThldIsPow) begin
        if (thld_level(thld_i.ready_thld) >= Depth) begin
          ready_thld_d = ThldWidth'($clog2(Depth) - 1);
        end
      end else if (32'(thld_i.ready_thld) >= Depth) begin
        ready_thld_d = ThldWidth'(Depth - 1);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_thld_q <= '0;
      reg_rst_we_o <= 1'b0;
    end else begin
      ready_thld_q <= ready_thld_d;
      // Tell the register the flush is done
      reg_rst_we_o <= reg_rst_i && fifo_empty;
    end
  end

  if (DataWidth == 64) begin : gen_qword
    logic dword_idx_q;

    always_ff @(posedge clk_i) begin
      if (req_i) begin
        if (dword_idx_q) begin
          fifo_wdata_q[63:32] <= data_i;
        end else begin
          fifo_wdata_q[31:0] <= data_i;
        end
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        dword_idx_q   <= 1'b0;
        fifo_wvalid_q <= 1'b0;
        ack_o         <= 1'b0;
      end else begin
        ack_o <= 1'b0;
        if (req_i) begin
          if (dword_idx_q) begin
            fifo_wvalid_q <= 1'b1;
          end else begin
            // Low dword is only stored, ack it right away
            dword_idx_q <= 1'b1;
            ack_o       <= 1'b1;
          end
        end
        if (fifo_wvalid_q && fifo_wready) begin
          fifo_wvalid_q <= 1'b0;
          dword_idx_q   <= 1'b0;
          ack_o         <= 1'b1;
        end
      end
    end

    a_push_high_dword: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (fifo_wvalid_q && fifo_wready) |-> dword_idx_q)
      else $error("Descriptor pushed before its high dword");
  end else begin : gen_dword
    always_ff @(posedge clk_i) begin
      if (req_i) begin
        fifo_wdata_q <= data_i;
      end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        fifo_wvalid_q <= 1'b0;
        ack_o         <= 1'b0;
      end else begin
        ack_o <= fifo_wvalid_q & fifo_wready;
        if (fifo_wvalid_q && fifo_wready) begin
          fifo_wvalid_q <= 1'b0;
        end else if (req_i) begin
          fifo_wvalid_q <= 1'b1;
        end
      end
    end
  end

  queue_fifo #(
    .Width(DataWidth),
    .Depth(Depth)
  ) u_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clr_i    (reg_rst_i),
    .wvalid_i (fifo_wvalid_q),
    .wready_o (fifo_wready),
    .wdata_i  (fifo_wdata_q),
    .rvalid_o (rvalid_o),
    .rready_i (rready_i),
    .rdata_o  (rdata_o),
    .depth_o  (fifo_depth),
    .full_o   (fifo_full)
  );

endmodule

// File: xfer_issuer.sv
// Transfer issuer FSM that pops descriptors and payload words and emits one beat per word
`timescale 1ns/1ps

module xfer_issuer (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  cmd_rvalid_i,
  input  xfer_pkg::cmd_desc_t   cmd_rdata_i,
  output logic                  cmd_rready_o,
  input  logic                  tx_rvalid_i,
  input  logic [31:0]           tx_rdata_i,
  output logic                  tx_rready_o,
  output xfer_pkg::xfer_beat_t  beat_o,
  output logic                  beat_valid_o
);
  import xfer_pkg::*;

  issuer_state_e state_q;
  issuer_state_e state_d;
  cmd_desc_t     desc_q;
  logic [7:0]    beats_left_q;
  logic          need_data;
  logic          beat_fire;
  xfer_beat_t    beat_d;

  // Zero-length writes still send one empty beat
  assign need_data = (desc_q.op == OP_WRITE) && (desc_q.len != 8'd0);

  always_comb begin
    state_d      = state_q;
    cmd_rready_o = 1'b0;
    tx_rready_o  = 1'b0;
    beat_fire    = 1'b0;
    unique case (state_q)
      ISS_IDLE: begin
        cmd_rready_o = cmd_rvalid_i;
        if (cmd_rvalid_i) begin
          state_d = ISS_FETCH;
        end
      end
      ISS_FETCH: state_d = ISS_BEAT;
      ISS_BEAT: begin
        tx_rready_o = need_data & tx_rvalid_i;
        beat_fire   = need_data ? tx_rvalid_i : 1'b1;
        if (beat_fire && beats_left_q == 8'd1) begin
          state_d = ISS_IDLE;
        end
      end
      default: state_d = ISS_IDLE;
    endcase
  end

  always_comb begin
    beat_d.op   = desc_q.op;
    beat_d.addr = desc_q.addr;
    beat_d.tag  = desc_q.tag;
    beat_d.data = need_data ? tx_rdata_i : 32'd0;
    beat_d.last = beat_fire && (beats_left_q == 8'd1);
  end

  always_ff @(posedge clk_i) begin
    if (cmd_rready_o) begin
      desc_q <= cmd_rdata_i;
    end
    beat_o <= beat_d;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ISS_IDLE;
      beats_left_q <= '0;
      beat_valid_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      beat_valid_o <= beat_fire;
      if (state_q == ISS_FETCH) begin
        beats_left_q <= need_data ? desc_q.len : 8'd1;
      end else if (beat_fire) begin
        beats_left_q <= beats_left_q - 1'b1;
      end
    end
  end

  a_tx_pop_write_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_rready_o |-> (state_q == ISS_BEAT && desc_q.op == OP_WRITE))
    else $error("Payload popped outside a write transfer");

  a_last_is_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    beat_o.last |-> beat_valid_o)
    else $error("Last flag on an invalid beat");

endmodule

// File: xfer_top.sv
// Transmit-side top level joining the command queue, the TX data queue and the issuer
`timescale 1ns/1ps

module xfer_top #(
  parameter int unsigned CmdDepth       = 16,
  parameter int unsigned TxDepth        = 64,
  parameter bit          ThldIsPow      = 1'b0,
  parameter bit          LimitReadyThld = 1'b1
) (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                cmd_req_i,
  input  logic [xfer_pkg::CsrDataWidth-1:0]   cmd_data_i,
  output logic                                cmd_ack_o,
  input  logic                                tx_req_i,
  input  logic [xfer_pkg::CsrDataWidth-1:0]   tx_data_i,
  output logic                                tx_ack_o,
  input  xfer_pkg::thld_cfg_t                 cmd_thld_i,
  input  xfer_pkg::thld_cfg_t                 tx_thld_i,
  output xfer_pkg::queue_status_t             cmd_status_o,
  output xfer_pkg::queue_status_t             tx_status_o,
  input  logic                                cmd_rst_i,
  input  logic                                tx_rst_i,
  output logic                                cmd_rst_we_o,
  output logic                                tx_rst_we_o,
  output xfer_pkg::xfer_beat_t                beat_o,
  output logic                                beat_valid_o
);
  import xfer_pkg::*;

  logic                    cmd_rvalid;
  logic                    cmd_rready;
  cmd_desc_t               cmd_rdata;
  logic                    tx_rvalid;
  logic                    tx_rready;
  logic [CsrDataWidth-1:0] tx_rdata;

  // Descriptors are two register writes wide
  write_queue #(
    .Depth          (CmdDepth),
    .DataWidth      (64),
    .ThldIsPow      (ThldIsPow),
    .LimitReadyThld (LimitReadyThld)
  ) u_cmd_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (cmd_req_i),
    .data_i       (cmd_data_i),
    .ack_o        (cmd_ack_o),
    .thld_i       (cmd_thld_i),
    .status_o     (cmd_status_o),
    .rvalid_o     (cmd_rvalid),
    .rready_i     (cmd_rready),
    .rdata_o      (cmd_rdata),
    .reg_rst_i    (cmd_rst_i),
    .reg_rst_we_o (cmd_rst_we_o)
  );

  write_queue #(
    .Depth          (TxDepth),
    .DataWidth      (CsrDataWidth),
    .ThldIsPow      (ThldIsPow),
    .LimitReadyThld (LimitReadyThld)
  ) u_tx_queue (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_i        (tx_req_i),
    .data_i       (tx_data_i),
    .ack_o        (tx_ack_o),
    .thld_i       (tx_thld_i),
    .status_o     (tx_status_o),
    .rvalid_o     (tx_rvalid),
    .rready_i     (tx_rready),
    .rdata_o      (tx_rdata),
    .reg_rst_i    (tx_rst_i),
    .reg_rst_we_o (tx_rst_we_o)
  );

  xfer_issuer u_issuer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_rvalid_i (cmd_rvalid),
    .cmd_rdata_i  (cmd_rdata),
    .cmd_rready_o (cmd_rready),
    .tx_rvalid_i  (tx_rvalid),
    .tx_rdata_i   (tx_rdata),
    .tx_rready_o  (tx_rready),
    .beat_o       (beat_o),
    .beat_valid_o (beat_valid_o)
  );

endmodule

// File: tb_xfer_top.sv
// Self-checking testbench for the transmit queues and issuer, compiled together with the RTL
`timescale 1ns/1ps

module tb_xfer_top;
  import xfer_pkg::*;

  localparam int unsigned CmdDepth = 16;
  localparam int unsigned TxDepth = 64;
  localparam int AckTimeout = 100;
  localparam int DrainLimit = 500;
  localparam int FlagCmdAck = 0;
  localparam int FlagTxAck = 1;
  localparam int FlagTxRstWe = 2;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   cmd_req;
  logic [31:0]            cmd_data;
  logic                   cmd_ack;
  logic                   tx_req;
  logic [31:0]            tx_data;
  logic                   tx_ack;
  thld_cfg_t              cmd_thld;
  thld_cfg_t              tx_thld;
  queue_status_t          cmd_status;
  queue_status_t          tx_status;
  logic                   cmd_rst;
  logic                   tx_rst;
  logic                   cmd_rst_we;
  logic                   tx_rst_we;
  xfer_beat_t             beat;
  logic                   beat_valid;
  // Scoreboard queue of expected beats, written in issue order and read by index
  xfer_beat_t             exp_mem [64];
  logic [5:0]             exp_wr;
  logic [5:0]             exp_rd;
  logic [ThldWidth-1:0]   ready_ref_q;
  logic                   we_ref_q;
  logic                   cmd_we_ref_q;
  logic                   start_exp;
  logic                   ready_exp;
  logic [QDepthWidth-1:0] tx_free;
  string                  test_name;
  int                     err_cnt;
  int                     err_base;
  int                     test_cnt;
  int                     seed;

  xfer_top #(
    .CmdDepth       (CmdDepth),
    .TxDepth        (TxDepth),
    .ThldIsPow      (1'b0),
    .LimitReadyThld (1'b1)
  ) u_dut (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmd_req_i    (cmd_req),
    .cmd_data_i   (cmd_data),
    .cmd_ack_o    (cmd_ack),
    .tx_req_i     (tx_req),
    .tx_data_i    (tx_data),
    .tx_ack_o     (tx_ack),
    .cmd_thld_i   (cmd_thld),
    .tx_thld_i    (tx_thld),
    .cmd_status_o (cmd_status),
    .tx_status_o  (tx_status),
    .cmd_rst_i    (cmd_rst),
    .tx_rst_i     (tx_rst),
    .cmd_rst_we_o (cmd_rst_we),
    .tx_rst_we_o  (tx_rst_we),
    .beat_o       (beat),
    .beat_valid_o (beat_valid)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // Status rules for the TX queue with linear thresholds
  assign tx_free   = QDepthWidth'(TxDepth) - tx_status.depth;
  assign start_exp = (tx_thld.start_thld != '0) &&
                     (tx_status.depth >= QDepthWidth'(tx_thld.start_thld));
  assign ready_exp = (ready_ref_q != '0) && (tx_free >= QDepthWidth'(ready_ref_q));

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_ref_q  <= '0;
      we_ref_q     <= 1'b0;
      cmd_we_ref_q <= 1'b0;
      exp_rd       <= '0;
    end else begin
      // Ready level lags its setting by one cycle
      // Clamp to depth minus one is out of reach for a 3-bit value at depth 64
      ready_ref_q  <= tx_thld.ready_thld;
      we_ref_q     <= tx_rst && tx_status.empty;
      cmd_we_ref_q <= cmd_rst && cmd_status.empty;
      if (beat_valid && exp_rd != exp_wr) begin
        exp_rd <= exp_rd + 1'b1;
      end
    end
  end

  function automatic void report_mismatch(string what, int exp_val, int act_val);
    $display("FAILED %s %s expected %0h actual %0h", test_name, what, exp_val, act_val);
    err_cnt++;
  endfunction

  a_beat_expected: assert property (@(negedge clk_i) disable iff (!rst_ni)
    beat_valid |-> (exp_rd != exp_wr))
    else begin
      $display("%s: beat emitted while no beat was expected", test_name);
      err_cnt++;
    end

  a_beat_match: assert property (@(negedge clk_i) disable iff (!rst_ni)
    (beat_valid && exp_rd != exp_wr) |-> (beat == exp_mem[exp_rd]))
    else begin
      $display("FAILED %s beat expected %h actual %h", test_name, exp_mem[exp_rd], beat);
      err_cnt++;
    end

  a_tx_start_trig: assert property (@(negedge clk_i) disable iff (!rst_ni)
    tx_status.start_trig == start_exp)
    else report_mismatch("tx start_trig", int'(start_exp), int'(tx_status.start_trig));

  a_tx_ready_trig: assert property (@(negedge clk_i) disable iff (!rst_ni)
    tx_status.ready_trig == ready_exp)
    else report_mismatch("tx ready_trig", int'(ready_exp), int'(tx_status.ready_trig));

  a_tx_rst_we: assert property (@(negedge clk_i) disable iff (!rst_ni)
    tx_rst_we == we_ref_q)
    else report_mismatch("tx rst_we", int'(we_ref_q), int'(tx_rst_we));

  a_cmd_rst_we: assert property (@(negedge clk_i) disable iff (!rst_ni)
    cmd_rst_we == cmd_we_ref_q)
    else report_mismatch("cmd rst_we", int'(cmd_we_ref_q), int'(cmd_rst_we));

  function automatic cmd_desc_t make_desc(xfer_op_e op, logic [6:0] addr, logic [7:0] len,
                                          logic [31:0] tag);
    cmd_desc_t d;
    d      = '0;
    d.op   = op;
    d.addr = addr;
    d.len  = len;
    d.tag  = tag;
    return d;
  endfunction

  function automatic void expect_beat(cmd_desc_t d, logic [31:0] data, logic last);
    xfer_beat_t b;
    b.op            = d.op;
    b.addr          = d.addr;
    b.tag           = d.tag;
    b.data          = data;
    b.last          = last;
    exp_mem[exp_wr] = b;
    exp_wr          = exp_wr + 1'b1;
  endfunction

  task automatic drive_req(input bit is_cmd, input logic [31:0] d);
    @(posedge clk_i);
    if (is_cmd) begin
      cmd_req  <= 1'b1;
      cmd_data <= d;
    end else begin
      tx_req  <= 1'b1;
      tx_data <= d;
    end
    @(posedge clk_i);
    cmd_req <= 1'b0;
    tx_req  <= 1'b0;
  endtask

  task automatic wait_flag(input int which, input string what);
    int n;
    bit seen;
    n    = 0;
    seen = 1'b0;
    while (!seen && n < AckTimeout) begin
      @(negedge clk_i);
      seen = (which == FlagCmdAck) ? cmd_ack : (which == FlagTxAck) ? tx_ack : tx_rst_we;
      n++;
    end
    if (!seen) begin
      $display("%s: timed out waiting for %s", test_name, what);
      err_cnt++;
    end
  endtask

  task automatic csr_write(input bit is_cmd, input logic [31:0] d);
    drive_req(is_cmd, d);
    if (is_cmd) begin
      wait_flag(FlagCmdAck, "command write ack");
    end else begin
      wait_flag(FlagTxAck, "TX write ack");
    end
  endtask

  // Low dword first, the high dword pushes the descriptor
  task automatic write_desc(input cmd_desc_t d);
    csr_write(1'b1, d[31:0]);
    csr_write(1'b1, d[63:32]);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_rd != exp_wr && n < DrainLimit) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_rd != exp_wr) begin
      $display("%s: expected beats did not arrive in time", test_name);
      err_cnt++;
    end
  endtask

  function automatic void begin_test(string name);
    test_name = name;
    err_base  = err_cnt;
  endfunction

  function automatic void end_test();
    test_cnt++;
    $display("test %s finished with %0d errors", test_name, err_cnt - err_base);
  endfunction

  initial begin
    cmd_desc_t   desc;
    logic [31:0] word;
    int          i;
    seed     = 81;
    err_cnt  = 0;
    err_base = 0;
    test_cnt = 0;
    exp_wr   = '0;
    rst_ni   <= 1'b0;
    cmd_req  <= 1'b0;
    cmd_data <= '0;
    tx_req   <= 1'b0;
    tx_data  <= '0;
    cmd_thld <= '0;
    tx_thld  <= '0;
    cmd_rst  <= 1'b0;
    tx_rst   <= 1'b0;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    begin_test("write_len3");
    desc = make_desc(OP_WRITE, 7'h15, 8'd3, 32'hA5A5_0001);
    write_desc(desc);
    for (i = 0; i < 3; i++) begin
      word = $random(seed);
      expect_beat(desc, word, i == 2);
      csr_write(1'b0, word);
    end
    wait_drain();
    end_test();

    // A parked TX word must survive a read transfer
    begin_test("read_no_data");
    word = $random(seed);
    csr_write(1'b0, word);
    desc = make_desc(OP_READ, 7'h33, 8'd0, 32'hBEEF_0002);
    expect_beat(desc, 32'd0, 1'b1);
    write_desc(desc);
    wait_drain();
    assert (tx_status.depth == QDepthWidth'(1))
      else report_mismatch("tx depth", 1, int'(tx_status.depth));
    assert (!tx_status.empty)
      else report_mismatch("tx empty at depth 1", 0, int'(tx_status.empty));
    end_test();

    begin_test("tx_thresholds");
    @(posedge clk_i);
    tx_thld <= '{start_thld: 3'd4, ready_thld: 3'd7};
    for (i = 1; i < 3; i++) begin
      word = $random(seed);
      csr_write(1'b0, word);
    end
    assert (!tx_status.start_trig)
      else report_mismatch("start_trig at depth 3", 0, int'(tx_status.start_trig));
    word = $random(seed);
    csr_write(1'b0, word);
    assert (tx_status.start_trig)
      else report_mismatch("start_trig at depth 4", 1, int'(tx_status.start_trig));
    // Leave 6 free entries, one short of the ready level
    for (i = 4; i < 58; i++) begin
      word = $random(seed);
      csr_write(1'b0, word);
    end
    assert (!tx_status.ready_trig)
      else report_mismatch("ready_trig with 6 free", 0, int'(tx_status.ready_trig));
    end_test();

    // The command queue is empty here, so its write-enable follows at once
    begin_test("tx_soft_reset");
    @(posedge clk_i);
    tx_rst  <= 1'b1;
    cmd_rst <= 1'b1;
    wait_flag(FlagTxRstWe, "TX soft reset write-enable");
    assert (tx_status.depth == '0)
      else report_mismatch("tx depth after flush", 0, int'(tx_status.depth));
    assert (tx_status.empty)
      else report_mismatch("tx empty after flush", 1, int'(tx_status.empty));
    @(posedge clk_i);
    tx_rst  <= 1'b0;
    cmd_rst <= 1'b0;
    end_test();

    begin_test("cmd_before_data");
    desc = make_desc(OP_WRITE, 7'h2A, 8'd2, 32'hC0DE_0003);
    write_desc(desc);
    repeat (12) begin
      @(negedge clk_i);
      assert (!beat_valid)
        else begin
          $display("%s: beat emitted while the TX queue was empty", test_name);
          err_cnt++;
        end
    end
    for (i = 0; i < 2; i++) begin
      word = $random(seed);
      expect_beat(desc, word, i == 1);
      csr_write(1'b0, word);
    end
    wait_drain();
    end_test();

    // A write without data parks the issuer so the command queue can fill
    begin_test("cmd_queue_full");
    desc = make_desc(OP_WRITE, 7'h11, 8'd1, 32'hF00D_0004);
    word = $random(seed);
    expect_beat(desc, word, 1'b1);
    write_desc(desc);
    for (i = 0; i < 16; i++) begin
      desc = make_desc(OP_NOP, 7'(i), 8'd0, 32'h0000_0100 + i);
      expect_beat(desc, 32'd0, 1'b1);
      write_desc(desc);
      // Full only once all 16 entries are held
      assert (cmd_status.full == (i == 15))
        else report_mismatch("cmd full", int'(i == 15), int'(cmd_status.full));
    end
    desc = make_desc(OP_NOP, 7'h7F, 8'd0, 32'h0000_01FF);
    expect_beat(desc, 32'd0, 1'b1);
    csr_write(1'b1, desc[31:0]);
    drive_req(1'b1, desc[63:32]);
    repeat (8) begin
      @(negedge clk_i);
      assert (!cmd_ack)
        else begin
          $display("%s: command ack given while the queue was full", test_name);
          err_cnt++;
        end
    end
    csr_write(1'b0, word);
    wait_flag(FlagCmdAck, "command ack after space freed");
    wait_drain();
    end_test();

    $display("tests run %0d, errors %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: all.f
xfer_pkg.sv
queue_fifo.sv
write_queue.sv
xfer_issuer.sv
xfer_top.sv
tb_xfer_top.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module tb_xfer_top -f all.f -o tb_sim \
  > build.log 2>&1 &&
./obj_dir/tb_sim > sim.log 2>&1
grep -q "TB PASSED" sim.log &&
  echo "Simulation passed" ||
  { echo "Simulation failed, see build.log and sim.log"; exit 1; }
